//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+hdl
hdl/cache_bank_pkg.sv
hdl/bank_req_stage.sv
hdl/bank_lookup.sv
hdl/bank_rsp_queue.sv
hdl/cache_bank.sv
dv/cache_bank_checker.sv
dv/cache_bank_tb.sv

//--- dv/cache_bank_checker.sv
`include "cache_bank_defs.svh"

module cache_bank_checker (
    input logic                              clk,
    input logic                              reset,
    input logic                              core_req_valid,
    input cache_bank_pkg::core_req_t         core_req,
    input logic                              core_req_ready,
    input logic                              core_rsp_valid,
    input cache_bank_pkg::core_rsp_t         core_rsp,
    input logic                              core_rsp_ready,
    input logic                              dram_fill_req_valid,
    input logic [`CB_LINE_ADDR_WIDTH-1:0]    dram_fill_req_addr,
    input logic                              dram_fill_req_ready,
    input logic                              dram_fill_rsp_ready,
    input logic                              dram_wb_req_valid,
    input cache_bank_pkg::wb_req_t           dram_wb_req,
    input logic                              dram_wb_req_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_bank_pkg::*;

    localparam int MEM_WORDS = 1 << `CB_WORD_ADDR_WIDTH;
    localparam int EXP_DEPTH = 16;

    int                              fail_count = 0;
    logic [`CB_WORD_WIDTH-1:0]       shadow [MEM_WORDS];
    core_rsp_t                       exp_mem [EXP_DEPTH];
    logic [3:0]                      exp_rd;
    logic [3:0]                      exp_wr;
    logic [4:0]                      exp_cnt;
    core_rsp_t                       exp_head;
    logic                            req_fire;
    logic                            rsp_fire;
    logic                            exp_push;
    logic                            exp_pop;
    // Youngest accepted write may still sit in stage 0
    logic                            undo_valid;
    logic [`CB_WORD_ADDR_WIDTH-1:0]  undo_addr;
    logic [`CB_WORD_WIDTH-1:0]       undo_word;
    logic [`CB_LINE_WIDTH-1:0]       wb_expect;

    function automatic logic [`CB_WORD_WIDTH-1:0] merge_word(
        input logic [`CB_WORD_WIDTH-1:0] old_word,
        input logic [`CB_WORD_WIDTH-1:0] new_word,
        input logic [`CB_WORD_BYTES-1:0] byteen
    );
        logic [`CB_WORD_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < `CB_WORD_BYTES; b++) begin
            if (byteen[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign req_fire = core_req_valid && core_req_ready;
    assign rsp_fire = core_rsp_valid && core_rsp_ready;
    assign exp_push = req_fire && (core_req.op == OP_READ);
    assign exp_pop  = rsp_fire && (exp_cnt != '0);
    assign exp_head = exp_mem[exp_rd];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                shadow[i] <= {16'hc0de, 16'(i)};
            end
            exp_rd     <= '0;
            exp_wr     <= '0;
            exp_cnt    <= '0;
            undo_valid <= 1'b0;
        end else begin
            if (req_fire) begin
                undo_valid <= (core_req.op == OP_WRITE);
                undo_addr  <= core_req.addr;
                undo_word  <= shadow[core_req.addr];
                if (core_req.op == OP_WRITE) begin
                    shadow[core_req.addr] <= merge_word(shadow[core_req.addr], core_req.data,
                                                        core_req.byteen);
                end
            end
            if (exp_push) begin
                exp_mem[exp_wr] <= '{tag: core_req.tag, data: shadow[core_req.addr]};
                exp_wr          <= exp_wr + 1'b1;
            end
            if (exp_pop) begin
                exp_rd <= exp_rd + 1'b1;
            end
            if (exp_push && !exp_pop) begin
                exp_cnt <= exp_cnt + 1'b1;
            end else if (exp_pop && !exp_push) begin
                exp_cnt <= exp_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        logic [`CB_WORD_ADDR_WIDTH-1:0] word_addr;
        for (int w = 0; w < `CB_WORDS_PER_LINE; w++) begin
            word_addr = {dram_wb_req.line_addr, `CB_WSEL_BITS'(w)};
            wb_expect[w*`CB_WORD_WIDTH +: `CB_WORD_WIDTH] =
                (undo_valid && (undo_addr == word_addr)) ? undo_word : shadow[word_addr];
        end
    end

    rsp_expected: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> exp_cnt != '0)
        else begin
            $error("core response transferred while no read was outstanding");
            fail_count++;
        end

    rsp_tag_ok: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> core_rsp.tag == exp_head.tag)
        else begin
            $error("mismatch at %0t: core_rsp.tag got %h expected %h",
                   $time, $sampled(core_rsp.tag), $sampled(exp_head.tag));
            fail_count++;
        end

    rsp_data_ok: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> core_rsp.data == exp_head.data)
        else begin
            $error("mismatch at %0t: core_rsp.data got %h expected %h",
                   $time, $sampled(core_rsp.data), $sampled(exp_head.data));
            fail_count++;
        end

    wb_data_ok: assert property (@(posedge clk) disable iff (reset)
        dram_wb_req_valid && dram_wb_req_ready |-> dram_wb_req.data == wb_expect)
        else begin
            $error("mismatch at %0t: dram_wb_req.data got %h expected %h",
                   $time, $sampled(dram_wb_req.data), $sampled(wb_expect));
            fail_count++;
        end

    fill_req_hold: assert property (@(posedge clk) disable iff (reset)
        dram_fill_req_valid && !dram_fill_req_ready
            |=> dram_fill_req_valid && $stable(dram_fill_req_addr))
        else begin
            $error("fill request dropped or changed its address before it transferred");
            fail_count++;
        end

    wb_req_hold: assert property (@(posedge clk) disable iff (reset)
        dram_wb_req_valid && !dram_wb_req_ready |=> dram_wb_req_valid && $stable(dram_wb_req))
        else begin
            $error("writeback request dropped or changed before it transferred");
            fail_count++;
        end

    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else begin
            $error("core response dropped or changed before it transferred");
            fail_count++;
        end

    reset_state_ok: assert property (@(posedge clk)
        $fell(reset) |-> !core_rsp_valid && !dram_fill_req_valid && !dram_wb_req_valid
                         && !dram_fill_rsp_ready && core_req_ready)
        else begin
            $error("outputs not in their idle state in the first cycle after reset");
            fail_count++;
        end

endmodule

bind cache_bank cache_bank_checker u_checker (
    .clk                 (clk),
    .reset               (reset),
    .core_req_valid      (core_req_valid),
    .core_req            (core_req),
    .core_req_ready      (core_req_ready),
    .core_rsp_valid      (core_rsp_valid),
    .core_rsp            (core_rsp),
    .core_rsp_ready      (core_rsp_ready),
    .dram_fill_req_valid (dram_fill_req_valid),
    .dram_fill_req_addr  (dram_fill_req_addr),
    .dram_fill_req_ready (dram_fill_req_ready),
    .dram_fill_rsp_ready (dram_fill_rsp_ready),
    .dram_wb_req_valid   (dram_wb_req_valid),
    .dram_wb_req         (dram_wb_req),
    .dram_wb_req_ready   (dram_wb_req_ready)
);

//--- dv/cache_bank_tb.sv
`include "cache_bank_defs.svh"

module cache_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_bank_pkg::*;

    localparam int NUM_REQUESTS = 2000;
    localparam int ADDR_SPAN    = 3 * (1 << `CB_SET_BITS) * `CB_WORDS_PER_LINE;
    localparam int REQ_TIMEOUT  = 200;
    localparam int RSP_TIMEOUT  = 200;
    localparam int DRAM_WORDS   = 1 << `CB_WORD_ADDR_WIDTH;

    logic                            clk;
    logic                            reset;
    logic                            core_req_valid;
    core_req_t                       core_req;
    logic                            core_req_ready;
    logic                            core_rsp_valid;
    core_rsp_t                       core_rsp;
    logic                            core_rsp_ready;
    logic                            dram_fill_req_valid;
    logic [`CB_LINE_ADDR_WIDTH-1:0]  dram_fill_req_addr;
    logic                            dram_fill_req_ready;
    logic                            dram_fill_rsp_valid;
    fill_rsp_t                       dram_fill_rsp;
    logic                            dram_fill_rsp_ready;
    logic                            dram_wb_req_valid;
    wb_req_t                         dram_wb_req;
    logic                            dram_wb_req_ready;

    logic [`CB_WORD_WIDTH-1:0]       dram_mem [DRAM_WORDS];
    int                              cycle;
    int                              accept_cycle [$];
    logic                            fill_pending;
    logic                            fill_fires;
    int                              fill_delay;
    logic [`CB_LINE_ADDR_WIDTH-1:0]  fill_addr;

    cache_bank i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
    end

    task automatic stop_with_failure(input string reason);
        $display("tests failed");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic [`CB_LINE_WIDTH-1:0] read_line(
        input logic [`CB_LINE_ADDR_WIDTH-1:0] line_addr
    );
        logic [`CB_LINE_WIDTH-1:0] line;
        for (int w = 0; w < `CB_WORDS_PER_LINE; w++) begin
            line[w*`CB_WORD_WIDTH +: `CB_WORD_WIDTH] =
                dram_mem[{line_addr, `CB_WSEL_BITS'(w)}];
        end
        return line;
    endfunction

    task automatic write_line(input wb_req_t wb);
        for (int w = 0; w < `CB_WORDS_PER_LINE; w++) begin
            dram_mem[{wb.line_addr, `CB_WSEL_BITS'(w)}] =
                wb.data[w*`CB_WORD_WIDTH +: `CB_WORD_WIDTH];
        end
    endtask

    function automatic core_req_t random_request(input logic [`CB_CORE_TAG_WIDTH-1:0] tag);
        core_req_t req;
        req.op     = ($urandom_range(1) == 0) ? OP_READ : OP_WRITE;
        req.byteen = `CB_WORD_BYTES'($urandom_range(15));
        req.addr   = `CB_WORD_ADDR_WIDTH'($urandom_range(ADDR_SPAN - 1));
        req.data   = $urandom;
        req.tag    = tag;
        return req;
    endfunction

    // Ready is known at the falling edge, so the transfer happens on the next rising edge
    task automatic send_request(input core_req_t req);
        int waited;
        waited         = 0;
        core_req_valid = 1'b1;
        core_req       = req;
        while (!core_req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > REQ_TIMEOUT) begin
                stop_with_failure("core request was not accepted within the timeout");
            end
        end
        if (req.op == OP_READ) begin
            accept_cycle.push_back(cycle);
        end
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    // Core response sink and DRAM model
    always @(negedge clk) begin
        if (!reset) begin
            if (fill_fires) begin
                dram_fill_rsp_valid = 1'b0;
            end
            core_rsp_ready      = ($urandom_range(3) != 0);
            dram_wb_req_ready   = ($urandom_range(2) != 0);
            dram_fill_req_ready = ($urandom_range(2) != 0);
            if (core_rsp_valid && core_rsp_ready && (accept_cycle.size() != 0)) begin
                void'(accept_cycle.pop_front());
            end
            if ((accept_cycle.size() != 0) && (cycle - accept_cycle[0] > RSP_TIMEOUT)) begin
                stop_with_failure("a read got no response within 200 cycles");
            end
            if (dram_wb_req_valid && dram_wb_req_ready) begin
                write_line(dram_wb_req);
            end
            if (dram_fill_req_valid && dram_fill_req_ready) begin
                fill_pending = 1'b1;
                fill_addr    = dram_fill_req_addr;
                fill_delay   = $urandom_range(6, 1);
            end else if (fill_pending) begin
                fill_delay--;
                if (fill_delay == 0) begin
                    dram_fill_rsp_valid = 1'b1;
                    dram_fill_rsp       = '{line_addr: fill_addr, data: read_line(fill_addr)};
                    fill_pending        = 1'b0;
                end
            end
            fill_fires = dram_fill_rsp_valid && dram_fill_rsp_ready;
        end
    end

    always @(negedge clk) begin
        if (i_dut.u_checker.fail_count != 0) begin
            stop_with_failure("assertion checks reported errors");
        end
    end

    initial begin
        logic [`CB_CORE_TAG_WIDTH-1:0] tag;
        int                            waited;
        void'($urandom(32'h766f_a5ea));
        clk                 = 1'b0;
        reset               = 1'b1;
        core_req_valid      = 1'b0;
        core_req            = '0;
        core_rsp_ready      = 1'b0;
        dram_fill_req_ready = 1'b0;
        dram_fill_rsp_valid = 1'b0;
        dram_fill_rsp       = '0;
        dram_wb_req_ready   = 1'b0;
        fill_pending        = 1'b0;
        fill_fires          = 1'b0;
        fill_delay          = 0;
        fill_addr           = '0;
        for (int i = 0; i < DRAM_WORDS; i++) begin
            dram_mem[i] = {16'hc0de, 16'(i)};
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        tag = '0;
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            if ($urandom_range(3) == 0) begin
                @(negedge clk);
            end
            send_request(random_request(tag));
            tag++;
        end

        waited = 0;
        while (accept_cycle.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > RSP_TIMEOUT) begin
                stop_with_failure("outstanding reads did not drain within the timeout");
            end
        end
        // Let the last response's checks run
        @(negedge clk);
        if (i_dut.u_checker.fail_count != 0) begin
            stop_with_failure("assertion checks reported errors");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- hdl/bank_lookup.sv
`include "cache_bank_defs.svh"

module bank_lookup (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              s0_valid,
    input  cache_bank_pkg::bank_req_t         s0_req,
    input  logic                              rsp_full,
    input  logic                              dram_fill_req_ready,
    input  logic                              dram_fill_rsp_valid,
    input  cache_bank_pkg::fill_rsp_t         dram_fill_rsp,
    input  logic                              dram_wb_req_ready,
    output logic                              s0_advance,
    output logic                              rsp_push,
    output cache_bank_pkg::core_rsp_t         rsp_data,
    output logic                              dram_fill_req_valid,
    output logic [`CB_LINE_ADDR_WIDTH-1:0]    dram_fill_req_addr,
    output logic                              dram_fill_rsp_ready,
    output logic                              dram_wb_req_valid,
    output cache_bank_pkg::wb_req_t           dram_wb_req
);
    import cache_bank_pkg::*;

    localparam int LINE_BYTES = `CB_WORDS_PER_LINE * `CB_WORD_BYTES;
    localparam int NUM_LINES  = 1 << `CB_SET_BITS;

    logic [`CB_TAG_BITS-1:0]   tag_mem  [NUM_LINES];
    logic [`CB_LINE_WIDTH-1:0] data_mem [NUM_LINES];
    logic [NUM_LINES-1:0]      valid_q;
    logic [NUM_LINES-1:0]      dirty_q;

    logic                      s1_valid;
    bank_req_t                 s1_req;
    miss_state_e               state;
    miss_state_e               state_next;

    logic [`CB_SET_BITS-1:0]   set_idx;
    logic [`CB_TAG_BITS-1:0]   req_tag;
    logic [`CB_LINE_WIDTH-1:0] rd_line;
    logic [`CB_LINE_WIDTH-1:0] merged_line;
    logic                      lookup_en;
    logic                      hit;
    logic                      miss;
    logic                      victim_dirty;
    logic                      s1_done;
    logic                      wr_hit;
    logic                      wb_fire;
    logic                      fill_fire;
    logic [`CB_SET_BITS-1:0]   fill_set;

    assign set_idx      = s1_req.line_addr[`CB_SET_BITS-1:0];
    assign req_tag      = s1_req.line_addr[`CB_LINE_ADDR_WIDTH-1 -: `CB_TAG_BITS];
    assign rd_line      = data_mem[set_idx];

    // Lookup only runs while no miss is in flight
    assign lookup_en    = s1_valid && (state == ST_LOOKUP);
    assign hit          = valid_q[set_idx] && (tag_mem[set_idx] == req_tag);
    assign miss         = lookup_en && !hit;
    assign victim_dirty = valid_q[set_idx] && dirty_q[set_idx];

    // A read hit waits for room in the response queue
    assign s1_done      = lookup_en && hit && ((s1_req.op == OP_WRITE) || !rsp_full);
    assign wr_hit       = s1_done && (s1_req.op == OP_WRITE);
    assign rsp_push     = s1_done && (s1_req.op == OP_READ);
    assign s0_advance   = !s1_valid || s1_done;

    assign rsp_data = '{
        tag:  s1_req.tag,
        data: rd_line[s1_req.wsel*`CB_WORD_WIDTH +: `CB_WORD_WIDTH]
    };

    always_comb begin
        merged_line = rd_line;
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (s1_req.mask[i]) begin
                merged_line[i*8 +: 8] = s1_req.data[i*8 +: 8];
            end
        end
    end

    // Victim address rebuilt from stored tag and index
    assign dram_wb_req_valid   = (state == ST_WRITEBACK);
    assign dram_wb_req         = '{line_addr: {tag_mem[set_idx], set_idx}, data: rd_line};
    assign wb_fire             = dram_wb_req_valid && dram_wb_req_ready;

    assign dram_fill_req_valid = (state == ST_FILL_REQ);
    assign dram_fill_req_addr  = s1_req.line_addr;

    assign dram_fill_rsp_ready = (state == ST_FILL_WAIT);
    assign fill_fire           = dram_fill_rsp_valid && dram_fill_rsp_ready;
    assign fill_set            = dram_fill_rsp.line_addr[`CB_SET_BITS-1:0];

    always_comb begin
        state_next = state;
        case (state)
            ST_LOOKUP: begin
                if (miss) begin
                    state_next = victim_dirty ? ST_WRITEBACK : ST_FILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                if (wb_fire) begin
                    state_next = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                if (dram_fill_req_ready) begin
                    state_next = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                if (fill_fire) begin
                    state_next = ST_LOOKUP;
                end
            end
            default: state_next = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_LOOKUP;
            s1_valid <= 1'b0;
            valid_q  <= '0;
            dirty_q  <= '0;
        end else begin
            state <= state_next;
            if (s0_advance) begin
                s1_valid <= s0_valid;
            end
            if (wr_hit) begin
                dirty_q[set_idx] <= 1'b1;
            end
            if (wb_fire) begin
                dirty_q[set_idx] <= 1'b0;
            end
            // Fill arrives clean
            if (fill_fire) begin
                valid_q[fill_set] <= 1'b1;
                dirty_q[fill_set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s0_advance && s0_valid) begin
            s1_req <= s0_req;
        end
        if (wr_hit) begin
            data_mem[set_idx] <= merged_line;
        end
        if (fill_fire) begin
            data_mem[fill_set] <= dram_fill_rsp.data;
            tag_mem[fill_set]  <= dram_fill_rsp.line_addr[`CB_LINE_ADDR_WIDTH-1 -: `CB_TAG_BITS];
        end
    end

endmodule

//--- hdl/bank_req_stage.sv
`include "cache_bank_defs.svh"

module bank_req_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      core_req_valid,
    input  cache_bank_pkg::core_req_t core_req,
    input  logic                      s0_advance,
    output logic                      core_req_ready,
    output logic                      s0_valid,
    output cache_bank_pkg::bank_req_t s0_req
);
    import cache_bank_pkg::*;

    logic [`CB_WSEL_BITS-1:0]                     wsel;
    logic [`CB_WORDS_PER_LINE*`CB_WORD_BYTES-1:0] line_mask;
    bank_req_t                                    req_in;

    assign wsel = core_req.addr[`CB_WSEL_BITS-1:0];

    // Reads carry an empty mask
    always_comb begin
        line_mask = '0;
        for (int w = 0; w < `CB_WORDS_PER_LINE; w++) begin
            if ((core_req.op == OP_WRITE) && (wsel == `CB_WSEL_BITS'(w))) begin
                line_mask[w*`CB_WORD_BYTES +: `CB_WORD_BYTES] = core_req.byteen;
            end
        end
    end

    assign req_in = '{
        op:        core_req.op,
        line_addr: core_req.addr[`CB_WORD_ADDR_WIDTH-1:`CB_WSEL_BITS],
        wsel:      wsel,
        data:      {`CB_WORDS_PER_LINE{core_req.data}},
        mask:      line_mask,
        tag:       core_req.tag
    };

    assign core_req_ready = !s0_valid || s0_advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid <= 1'b0;
        end else if (core_req_ready) begin
            s0_valid <= core_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (core_req_valid && core_req_ready) begin
            s0_req <= req_in;
        end
    end

endmodule

//--- hdl/bank_rsp_queue.sv
`include "cache_bank_defs.svh"

module bank_rsp_queue (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rsp_push,
    input  cache_bank_pkg::core_rsp_t rsp_data,
    input  logic                      core_rsp_ready,
    output logic                      rsp_full,
    output logic                      core_rsp_valid,
    output cache_bank_pkg::core_rsp_t core_rsp
);
    import cache_bank_pkg::*;

    localparam int PTR_BITS = $clog2(`CB_RSPQ_DEPTH);

    core_rsp_t           mem [`CB_RSPQ_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                pop;

    assign core_rsp_valid = (count != '0);
    assign rsp_full       = (count == (PTR_BITS+1)'(`CB_RSPQ_DEPTH));
    assign core_rsp       = mem[rd_ptr];
    assign pop            = core_rsp_valid && core_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rsp_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`CB_RSPQ_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`CB_RSPQ_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count holds when both happen
            if (rsp_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !rsp_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_push) begin
            mem[wr_ptr] <= rsp_data;
        end
    end

endmodule

//--- hdl/cache_bank.sv
`include "cache_bank_defs.svh"

module cache_bank (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              core_req_valid,
    input  cache_bank_pkg::core_req_t         core_req,
    output logic                              core_req_ready,

    output logic                              core_rsp_valid,
    output cache_bank_pkg::core_rsp_t         core_rsp,
    input  logic                              core_rsp_ready,

    output logic                              dram_fill_req_valid,
    output logic [`CB_LINE_ADDR_WIDTH-1:0]    dram_fill_req_addr,
    input  logic                              dram_fill_req_ready,

    input  logic                              dram_fill_rsp_valid,
    input  cache_bank_pkg::fill_rsp_t         dram_fill_rsp,
    output logic                              dram_fill_rsp_ready,

    output logic                              dram_wb_req_valid,
    output cache_bank_pkg::wb_req_t           dram_wb_req,
    input  logic                              dram_wb_req_ready
);
    import cache_bank_pkg::*;

    logic      s0_valid;
    bank_req_t s0_req;
    logic      s0_advance;
    logic      rsp_push;
    core_rsp_t rsp_data;
    logic      rsp_full;

    bank_req_stage u_req_stage (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .s0_advance     (s0_advance),
        .core_req_ready (core_req_ready),
        .s0_valid       (s0_valid),
        .s0_req         (s0_req)
    );

    bank_lookup u_lookup (
        .clk                 (clk),
        .reset               (reset),
        .s0_valid            (s0_valid),
        .s0_req              (s0_req),
        .rsp_full            (rsp_full),
        .dram_fill_req_ready (dram_fill_req_ready),
        .dram_fill_rsp_valid (dram_fill_rsp_valid),
        .dram_fill_rsp       (dram_fill_rsp),
        .dram_wb_req_ready   (dram_wb_req_ready),
        .s0_advance          (s0_advance),
        .rsp_push            (rsp_push),
        .rsp_data            (rsp_data),
        .dram_fill_req_valid (dram_fill_req_valid),
        .dram_fill_req_addr  (dram_fill_req_addr),
        .dram_fill_rsp_ready (dram_fill_rsp_ready),
        .dram_wb_req_valid   (dram_wb_req_valid),
        .dram_wb_req         (dram_wb_req)
    );

    bank_rsp_queue u_rsp_queue (
        .clk            (clk),
        .reset          (reset),
        .rsp_push       (rsp_push),
        .rsp_data       (rsp_data),
        .core_rsp_ready (core_rsp_ready),
        .rsp_full       (rsp_full),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp)
    );

endmodule

//--- hdl/cache_bank_defs.svh
`ifndef CACHE_BANK_DEFS_SVH
`define CACHE_BANK_DEFS_SVH

// Word geometry
`define CB_WORD_WIDTH        32
`define CB_WORD_BYTES        4

// Line geometry
`define CB_WORDS_PER_LINE    4
`define CB_WSEL_BITS         2
`define CB_LINE_WIDTH        128

// Address split into tag then index
`define CB_SET_BITS          4
`define CB_TAG_BITS          6
`define CB_LINE_ADDR_WIDTH   10
`define CB_WORD_ADDR_WIDTH   12

`define CB_CORE_TAG_WIDTH    8
`define CB_RSPQ_DEPTH        4

`endif

//--- hdl/cache_bank_pkg.sv
`include "cache_bank_defs.svh"

package cache_bank_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    typedef enum logic [1:0] {
        ST_LOOKUP    = 2'd0,
        ST_WRITEBACK = 2'd1,
        ST_FILL_REQ  = 2'd2,
        ST_FILL_WAIT = 2'd3
    } miss_state_e;

    typedef struct packed {
        req_op_e                                      op;
        logic [`CB_WORD_BYTES-1:0]                    byteen;
        logic [`CB_WORD_ADDR_WIDTH-1:0]               addr;
        logic [`CB_WORD_WIDTH-1:0]                    data;
        logic [`CB_CORE_TAG_WIDTH-1:0]                tag;
    } core_req_t;

    typedef struct packed {
        logic [`CB_CORE_TAG_WIDTH-1:0]                tag;
        logic [`CB_WORD_WIDTH-1:0]                    data;
    } core_rsp_t;

    // Write word and byte enables already placed at their line position
    typedef struct packed {
        req_op_e                                      op;
        logic [`CB_LINE_ADDR_WIDTH-1:0]               line_addr;
        logic [`CB_WSEL_BITS-1:0]                     wsel;
        logic [`CB_LINE_WIDTH-1:0]                    data;
        logic [`CB_WORDS_PER_LINE*`CB_WORD_BYTES-1:0] mask;
        logic [`CB_CORE_TAG_WIDTH-1:0]                tag;
    } bank_req_t;

    typedef struct packed {
        logic [`CB_LINE_ADDR_WIDTH-1:0]               line_addr;
        logic [`CB_LINE_WIDTH-1:0]                    data;
    } fill_rsp_t;

    typedef struct packed {
        logic [`CB_LINE_ADDR_WIDTH-1:0]               line_addr;
        logic [`CB_LINE_WIDTH-1:0]                    data;
    } wb_req_t;

endpackage
